/* include/lsu_defines.svh */
/*
 * Load/store unit sizing macros
 */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Instruction id width
`define LSU_ID_W 4

// Scratch memory size, in 32-bit words
`define LSU_SCRATCH_WORDS 1024

// Bus master request queue entries
`define LSU_BUS_QUEUE_DEPTH 4

// Load attribute entries
// Also the cap on loads in flight
`define LSU_ATTR_DEPTH 4

`endif

/* source/lsu_pkg.sv */
/*
 * Load/store unit types: issue, sub-unit request, load attributes,
 * external bus command and writeback, plus the fn3 encodings
 */
`include "lsu_defines.svh"

package lsu_pkg;

    // RISC-V load/store width field
    localparam logic [2:0] fn_b  = 3'd0;
    localparam logic [2:0] fn_h  = 3'd1;
    localparam logic [2:0] fn_w  = 3'd2;
    localparam logic [2:0] fn_bu = 3'd4;
    localparam logic [2:0] fn_hu = 3'd5;

    // One memory instruction from issue
    typedef struct packed {
        logic [31:0]           rs1;
        logic [31:0]           rs2;
        logic [11:0]           offset;
        logic [2:0]            fn3;
        logic                  load;
        logic                  store;
        logic [`LSU_ID_W-1:0]  id;
    } issue_t;

    // Request seen by both sub-units
    typedef struct packed {
        logic [29:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        load;
    } mem_req_t;

    // Kept per outstanding load
    typedef struct packed {
        logic [2:0]           fn3;
        logic [1:0]           byte_addr;
        logic [`LSU_ID_W-1:0] id;
        logic                 unit;
    } load_attr_t;

    // External bus command
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        we;
    } bus_cmd_t;

    typedef struct packed {
        logic                 done;
        logic [`LSU_ID_W-1:0] id;
        logic [31:0]          data;
    } writeback_t;

endpackage

/* source/lsu_fifo.sv */
/*
 * Small synchronous FIFO, payload chosen by type parameter
 */
module lsu_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           entries [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    // Overflow and underflow requests are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & valid;

    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign data_out = entries[rd_ptr];

    // Storage, no reset needed
    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= data_in;
    end

    // Pointers wrap at DEPTH, not only at powers of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/scratch_mem.sv */
/*
 * Local scratch data memory: byte-enable writes, one-cycle read
 */
`include "lsu_defines.svh"

module scratch_mem (
    input  logic              clk,
    input  logic              arst_n,
    input  lsu_pkg::mem_req_t req,
    input  logic              req_valid,
    output logic              ready,
    output logic              rvalid,
    output logic [31:0]       rdata
);

    localparam int IDX_W = $clog2(`LSU_SCRATCH_WORDS);

    logic [31:0]      mem [`LSU_SCRATCH_WORDS];
    logic [IDX_W-1:0] idx;
    logic             wr_en;
    logic             rd_en;

    // Accepts a request every cycle
    assign ready = 1'b1;

    // Only the low word address bits index the array
    assign idx = req.addr[IDX_W-1:0];

    assign wr_en = req_valid & ~req.load;
    assign rd_en = req_valid & req.load;

    //////////////////////////////
    // Array access
    //////////////////////////////

    // Write enabled bytes only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    // Registered read word
    always_ff @(posedge clk) begin
        if (rd_en)
            rdata <= mem[idx];
    end

    //////////////////////////////
    // Read valid
    //////////////////////////////

    // One cycle after the load request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            rvalid <= 1'b0;
        else
            rvalid <= rd_en;
    end

endmodule

/* source/bus_master.sv */
/*
 * External bus master: queues sub-unit requests and runs them
 * one at a time as req/ack transfers
 */
`include "lsu_defines.svh"

module bus_master (
    input  logic              clk,
    input  logic              arst_n,
    input  lsu_pkg::mem_req_t req,
    input  logic              req_valid,
    output logic              ready,
    output logic              rvalid,
    output logic [31:0]       rdata,
    output logic              bus_req,
    output logic [31:0]       bus_addr,
    output logic [3:0]        bus_be,
    output logic [31:0]       bus_wdata,
    output logic              bus_we,
    input  logic              bus_ack,
    input  logic [31:0]       bus_rdata
);

    lsu_pkg::mem_req_t head;
    lsu_pkg::bus_cmd_t cmd;
    logic              head_valid;
    logic              queue_full;
    logic              done;

    //////////////////////////////
    // Request queue
    //////////////////////////////

    lsu_fifo #(
        .payload_t (lsu_pkg::mem_req_t),
        .DEPTH     (`LSU_BUS_QUEUE_DEPTH)
    ) req_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (req_valid),
        .pop      (done),
        .data_in  (req),
        .data_out (head),
        .valid    (head_valid),
        .full     (queue_full)
    );

    // Back-pressure once all entries are taken
    assign ready = ~queue_full;

    //////////////////////////////
    // Bus side
    //////////////////////////////

    // Head entry forms the bus command
    assign cmd.addr  = {head.addr, 2'b00};
    assign cmd.be    = head.be;
    assign cmd.wdata = head.wdata;
    assign cmd.we    = ~head.load;

    // Held until acked, next one may follow a cycle later
    assign bus_req   = head_valid;
    assign bus_addr  = cmd.addr;
    assign bus_be    = cmd.be;
    assign bus_wdata = cmd.wdata;
    assign bus_we    = cmd.we;

    // Ack retires the head
    assign done = bus_ack & head_valid;

    // Loads return in the ack cycle
    // stores finish without rvalid
    assign rvalid = done & head.load;
    assign rdata  = bus_rdata;

endmodule

/* source/load_store_unit.sv */
/*
 * Load/store unit: address generation, sub-unit routing with switch
 * stall, load attribute tracking and load data alignment
 */
`include "lsu_defines.svh"

module load_store_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  lsu_pkg::issue_t     issue,
    input  logic                issue_valid,
    output logic                issue_ready,
    output lsu_pkg::mem_req_t   req,
    output logic                scratch_req_valid,
    output logic                bus_req_valid,
    input  logic                scratch_ready,
    input  logic                bus_ready,
    input  logic                scratch_rvalid,
    input  logic                bus_rvalid,
    input  logic [31:0]         scratch_rdata,
    input  logic [31:0]         bus_rdata,
    output lsu_pkg::writeback_t wb
);

    logic [31:0]         eff_addr;
    logic                unit;
    logic [3:0]          be;
    logic [31:0]         wdata;
    logic                accept;
    logic                mem_op;
    logic                unit_diff;
    logic                switch_stall;
    logic                last_unit;
    logic                load_done;
    lsu_pkg::load_attr_t attr_in;
    lsu_pkg::load_attr_t attr_head;
    logic                attr_valid;
    logic                attr_full;
    logic [31:0]         raw_data;
    logic [15:0]         half_sel;
    logic [7:0]          byte_sel;
    logic [31:0]         load_data;

    //////////////////////////////
    // Address and store lanes
    //////////////////////////////

    assign eff_addr = issue.rs1 + 32'(signed'(issue.offset));

    // Bit 31 picks the sub-unit, 1 is bus
    assign unit = eff_addr[31];

    // Byte enables, none for loads
    always_comb begin
        case (issue.fn3[1:0])
            lsu_pkg::fn_b[1:0]: be = 4'b0001 << eff_addr[1:0];
            lsu_pkg::fn_h[1:0]: be = eff_addr[1] ? 4'b1100 : 4'b0011;
            default:            be = 4'b1111;
        endcase
        if (issue.load)
            be = 4'b0000;
    end

    // Replicated data lands in every lane the enables can pick
    always_comb begin
        case (issue.fn3[1:0])
            lsu_pkg::fn_b[1:0]: wdata = {4{issue.rs2[7:0]}};
            lsu_pkg::fn_h[1:0]: wdata = {2{issue.rs2[15:0]}};
            default:            wdata = issue.rs2;
        endcase
    end

    assign req.addr  = eff_addr[31:2];
    assign req.be    = be;
    assign req.wdata = wdata;
    assign req.load  = issue.load;

    //////////////////////////////
    // Issue control
    //////////////////////////////

    // Different target than the last load while loads are pending
    assign unit_diff = (unit != last_unit) & attr_valid;

    // Never looks at issue_valid
    assign issue_ready = scratch_ready & bus_ready & ~switch_stall
                         & ~unit_diff & ~attr_full;

    assign mem_op = issue.load | issue.store;
    assign accept = issue_valid & issue_ready & mem_op;

    assign scratch_req_valid = accept & ~unit;
    assign bus_req_valid     = accept & unit;

    // Switch stall holds until outstanding loads drain
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            switch_stall <= 1'b0;
        else if (!attr_valid)
            switch_stall <= 1'b0;
        else if (issue_valid & mem_op & unit_diff)
            switch_stall <= 1'b1;
    end

    // Unit of the most recent load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            last_unit <= 1'b0;
        else if (accept & issue.load)
            last_unit <= unit;
    end

    //////////////////////////////
    // Load attributes
    //////////////////////////////

    assign attr_in.fn3       = issue.fn3;
    assign attr_in.byte_addr = eff_addr[1:0];
    assign attr_in.id        = issue.id;
    assign attr_in.unit      = unit;

    assign load_done = scratch_rvalid | bus_rvalid;

    lsu_fifo #(
        .payload_t (lsu_pkg::load_attr_t),
        .DEPTH     (`LSU_ATTR_DEPTH)
    ) attr_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (accept & issue.load),
        .pop      (load_done),
        .data_in  (attr_in),
        .data_out (attr_head),
        .valid    (attr_valid),
        .full     (attr_full)
    );

    //////////////////////////////
    // Load data return
    //////////////////////////////

    assign raw_data = attr_head.unit ? bus_rdata : scratch_rdata;

    // Halfword first, then byte within it
    assign half_sel = attr_head.byte_addr[1] ? raw_data[31:16] : raw_data[15:0];
    assign byte_sel = attr_head.byte_addr[0] ? half_sel[15:8] : half_sel[7:0];

    // Sign or zero extension
    always_comb begin
        case (attr_head.fn3)
            lsu_pkg::fn_b:  load_data = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::fn_h:  load_data = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::fn_bu: load_data = {24'd0, byte_sel};
            lsu_pkg::fn_hu: load_data = {16'd0, half_sel};
            default:        load_data = raw_data;
        endcase
    end

    // Same cycle as the sub-unit rvalid
    assign wb.done = load_done;
    assign wb.id   = attr_head.id;
    assign wb.data = load_data;

endmodule

/* source/lsu_top.sv */
/*
 * Load/store subsystem top: unit, scratch memory and bus master
 */
module lsu_top (
    input  logic                clk,
    input  logic                arst_n,
    input  lsu_pkg::issue_t     issue,
    input  logic                issue_valid,
    output logic                issue_ready,
    output lsu_pkg::writeback_t wb,
    output logic                bus_req,
    output logic [31:0]         bus_addr,
    output logic [3:0]          bus_be,
    output logic [31:0]         bus_wdata,
    output logic                bus_we,
    input  logic                bus_ack,
    input  logic [31:0]         bus_rdata
);

    lsu_pkg::mem_req_t req;
    logic              scratch_req_valid;
    logic              bus_req_valid;
    logic              scratch_ready;
    logic              bus_ready;
    logic              scratch_rvalid;
    logic              bus_rvalid;
    logic [31:0]       scratch_rdata;
    logic [31:0]       bus_load_data;

    load_store_unit lsu (
        .clk               (clk),
        .arst_n            (arst_n),
        .issue             (issue),
        .issue_valid       (issue_valid),
        .issue_ready       (issue_ready),
        .req               (req),
        .scratch_req_valid (scratch_req_valid),
        .bus_req_valid     (bus_req_valid),
        .scratch_ready     (scratch_ready),
        .bus_ready         (bus_ready),
        .scratch_rvalid    (scratch_rvalid),
        .bus_rvalid        (bus_rvalid),
        .scratch_rdata     (scratch_rdata),
        .bus_rdata         (bus_load_data),
        .wb                (wb)
    );

    // Single-cycle local memory
    scratch_mem scratch (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (scratch_req_valid),
        .ready     (scratch_ready),
        .rvalid    (scratch_rvalid),
        .rdata     (scratch_rdata)
    );

    // Variable-latency external path
    bus_master bus (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (bus_req_valid),
        .ready     (bus_ready),
        .rvalid    (bus_rvalid),
        .rdata     (bus_load_data),
        .bus_req   (bus_req),
        .bus_addr  (bus_addr),
        .bus_be    (bus_be),
        .bus_wdata (bus_wdata),
        .bus_we    (bus_we),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

endmodule

/* bench/lsu_tb.sv */
/*
 * Load/store unit testbench with xorshift stimulus, a bus responder,
 * a byte-level memory model and writeback checks
 */
`include "lsu_defines.svh"

module lsu_tb;

    // Word stores fill both windows before the random run
    localparam int N_INIT      = 32;
    localparam int N_TOTAL     = N_INIT + 600;
    localparam int CYCLE_LIMIT = N_TOTAL * (6 + 4) + 200;
    localparam logic [31:0] SEED = 32'hf4fed083;

    // Expected writeback of one accepted load
    typedef struct packed {
        logic [31:0]          data;
        logic [`LSU_ID_W-1:0] id;
        logic                 scratch;
        int                   due;
    } exp_load_t;

    logic                clk = 1'b0;
    logic                arst_n;
    lsu_pkg::issue_t     issue;
    logic                issue_valid;
    logic                issue_ready;
    lsu_pkg::writeback_t wb;
    logic                bus_req;
    logic [31:0]         bus_addr;
    logic [3:0]          bus_be;
    logic [31:0]         bus_wdata;
    logic                bus_we;
    logic                bus_ack;
    logic [31:0]         bus_rdata;

    // Model holds 64 bytes per window with scratch first
    logic [7:0]        ref_mem [128];
    logic [31:0]       bus_mem [16];
    exp_load_t         exp_q [$];
    lsu_pkg::bus_cmd_t bus_q [$];
    logic [31:0]       stim_state = SEED;
    logic [31:0]       cur_addr;
    int                cur_size;
    logic              hold;
    int                drain;
    int                cycles     = 0;
    int                errors     = 0;
    int                bus_errors = 0;
    int                issued     = 0;
    int                loads_done = 0;

    lsu_top DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .wb          (wb),
        .bus_req     (bus_req),
        .bus_addr    (bus_addr),
        .bus_be      (bus_be),
        .bus_wdata   (bus_wdata),
        .bus_we      (bus_we),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata)
    );

    always #4 clk = ~clk;

    // Cycle count against the run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run hit the cycle limit of %0d before all loads finished", CYCLE_LIMIT);
            $display("Closing: %0d writeback errors, %0d bus errors", errors, bus_errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Model byte index with the bus window in the upper half
    function automatic int ref_index(input logic [31:0] addr);
        return (addr[31] ? 64 : 0) + int'(addr[5:0]);
    endfunction

    // Aligned and extended load value from the model bytes
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [2:0] fn);
        int          i;
        int          j;
        logic [31:0] w;
        i = ref_index(addr);
        j = i - (i % 4);
        w = {ref_mem[j + 3], ref_mem[j + 2], ref_mem[j + 1], ref_mem[j]};
        w = w >> (8 * (i % 4));
        case (fn)
            lsu_pkg::fn_b:  return {{24{w[7]}}, w[7:0]};
            lsu_pkg::fn_h:  return {{16{w[15]}}, w[15:0]};
            lsu_pkg::fn_bu: return {24'd0, w[7:0]};
            lsu_pkg::fn_hu: return {16'd0, w[15:0]};
            default:        return w;
        endcase
    endfunction

    // New instruction with rs1 backed out of the chosen target and offset
    task automatic build_instruction();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [1:0]  byte_off;
        int          sel;
        stim_state = xorshift32(stim_state);
        r1 = stim_state;
        stim_state = xorshift32(stim_state);
        r2 = stim_state;
        stim_state = xorshift32(stim_state);
        issue.rs2 = stim_state;
        if (issued < N_INIT) begin
            issue.load  = 1'b0;
            issue.fn3   = lsu_pkg::fn_w;
            r1[5:1]     = {issued[3:0], issued[4]};
        end else begin
            issue.load = r1[0];
            sel = int'(r1[31:8] % 24'd5);
            if (!r1[0])
                sel = int'(r1[31:8] % 24'd3);
            case (sel)
                0:       issue.fn3 = lsu_pkg::fn_b;
                1:       issue.fn3 = lsu_pkg::fn_h;
                2:       issue.fn3 = lsu_pkg::fn_w;
                3:       issue.fn3 = lsu_pkg::fn_bu;
                default: issue.fn3 = lsu_pkg::fn_hu;
            endcase
        end
        issue.store = ~issue.load;
        // Natural alignment only
        case (issue.fn3)
            lsu_pkg::fn_b, lsu_pkg::fn_bu: begin
                cur_size = 1;
                byte_off = r1[7:6];
            end
            lsu_pkg::fn_h, lsu_pkg::fn_hu: begin
                cur_size = 2;
                byte_off = {r1[7], 1'b0};
            end
            default: begin
                cur_size = 4;
                byte_off = 2'b00;
            end
        endcase
        if (issued < N_INIT)
            byte_off = 2'b00;
        cur_addr     = {r1[1], 31'h0000_0100} | {26'd0, r1[5:2], byte_off};
        issue.offset = r2[11:0];
        issue.rs1    = cur_addr - {{20{r2[11]}}, r2[11:0]};
        issue.id     = issued[`LSU_ID_W-1:0];
    endtask

    // Model update for a transfer seen before its edge
    task automatic record_accepted();
        lsu_pkg::bus_cmd_t cmd;
        exp_load_t         e;
        logic [3:0]        be;
        logic [31:0]       lanes;
        int                i;
        int                k;
        int                lane;
        i     = ref_index(cur_addr);
        be    = 4'b0000;
        lanes = '0;
        if (issue.store) begin
            for (k = 0; k < cur_size; k++) begin
                lane = int'(cur_addr[1:0]) + k;
                ref_mem[i + k]       = issue.rs2[8*k +: 8];
                be[lane]             = 1'b1;
                lanes[8*lane +: 8]   = issue.rs2[8*k +: 8];
            end
        end else begin
            e.data    = expected_load(cur_addr, issue.fn3);
            e.id      = issue.id;
            e.scratch = ~cur_addr[31];
            e.due     = cycles + 1;
            exp_q.push_back(e);
        end
        if (cur_addr[31]) begin
            cmd.addr  = {cur_addr[31:2], 2'b00};
            cmd.be    = be;
            cmd.wdata = lanes;
            cmd.we    = issue.store;
            bus_q.push_back(cmd);
        end
    endtask

    task automatic check_writeback();
        exp_load_t e;
        if (wb.done) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Writeback at %0t with no load outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                loads_done++;
                assert (wb.data == e.data) else begin
                    errors++;
                    $display("FAIL %0t wb.data got %h expected %h", $time, wb.data, e.data);
                end
                assert (wb.id == e.id) else begin
                    errors++;
                    $display("FAIL %0t wb.id got %0d expected %0d", $time, wb.id, e.id);
                end
                if (e.scratch) begin
                    assert (cycles == e.due) else begin
                        errors++;
                        $display("Scratch load id %0d came back in cycle %0d, not %0d",
                                 e.id, cycles, e.due);
                    end
                end else begin
                    // Bus loads complete in their ack cycle
                    assert (bus_ack) else begin
                        errors++;
                        $display("Bus load id %0d wrote back at %0t outside its bus_ack cycle",
                                 e.id, $time);
                    end
                end
            end
        end
    endtask

    // Head of the expected bus accesses against the bus pins
    task automatic check_bus_command();
        lsu_pkg::bus_cmd_t e;
        logic [31:0]       mask;
        assert (bus_q.size() != 0) else begin
            bus_errors++;
            $display("Bus request at %0t with no bus access issued", $time);
        end
        if (bus_q.size() != 0) begin
            e    = bus_q.pop_front();
            mask = {{8{e.be[3]}}, {8{e.be[2]}}, {8{e.be[1]}}, {8{e.be[0]}}};
            assert (bus_addr == e.addr) else begin
                bus_errors++;
                $display("FAIL %0t bus_addr got %h expected %h", $time, bus_addr, e.addr);
            end
            assert (bus_we == e.we) else begin
                bus_errors++;
                $display("FAIL %0t bus_we got %b expected %b", $time, bus_we, e.we);
            end
            assert (bus_be == e.be) else begin
                bus_errors++;
                $display("FAIL %0t bus_be got %b expected %b", $time, bus_be, e.be);
            end
            assert ((bus_wdata & mask) == e.wdata) else begin
                bus_errors++;
                $display("FAIL %0t bus_wdata got %h expected %h", $time,
                         bus_wdata & mask, e.wdata);
            end
        end
    endtask

    //////////////////////////////
    // Bus responder
    //////////////////////////////

    initial begin : responder
        logic        busy;
        logic        ack_next;
        logic [31:0] rdata_next;
        logic [31:0] delay_state;
        int          wait_cnt;
        int          k;
        bus_ack     = 1'b0;
        bus_rdata   = '0;
        busy        = 1'b0;
        ack_next    = 1'b0;
        rdata_next  = '0;
        wait_cnt    = 0;
        delay_state = SEED;
        for (k = 0; k < 16; k++)
            bus_mem[k] = (32'h8000_0100 | (k << 2)) ^ 32'hc3a5_5a3c;
        forever begin
            @(negedge clk);
            ack_next = 1'b0;
            if (bus_ack) begin
                // Transfer ends at the coming edge
                if (bus_we) begin
                    for (k = 0; k < 4; k++) begin
                        if (bus_be[k])
                            bus_mem[bus_addr[5:2]][8*k +: 8] = bus_wdata[8*k +: 8];
                    end
                end
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    ack_next   = 1'b1;
                    rdata_next = bus_mem[bus_addr[5:2]];
                end else
                    wait_cnt--;
            end else if (bus_req) begin
                check_bus_command();
                busy        = 1'b1;
                delay_state = xorshift32(delay_state);
                wait_cnt    = int'(delay_state % 32'd6);
                if (wait_cnt == 0) begin
                    ack_next   = 1'b1;
                    rdata_next = bus_mem[bus_addr[5:2]];
                end
            end
            @(posedge clk);
            #1;
            bus_ack   = ack_next;
            bus_rdata = rdata_next;
        end
    end

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////

    initial begin : stimulus
        arst_n      = 1'b0;
        issue       = '0;
        issue_valid = 1'b0;
        hold        = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Idle outputs after reset
        @(negedge clk);
        assert (!wb.done) else begin
            errors++;
            $display("FAIL %0t wb.done got %b expected 0", $time, wb.done);
        end
        assert (!bus_req) else begin
            errors++;
            $display("FAIL %0t bus_req got %b expected 0", $time, bus_req);
        end
        assert (issue_ready) else begin
            errors++;
            $display("FAIL %0t issue_ready got %b expected 1", $time, issue_ready);
        end

        while (issued < N_TOTAL) begin
            @(posedge clk);
            #1;
            // A refused instruction stays on the inputs
            if (!hold) begin
                stim_state = xorshift32(stim_state);
                if (issued < N_INIT || stim_state[1:0] != 2'b00) begin
                    build_instruction();
                    issue_valid = 1'b1;
                end else
                    issue_valid = 1'b0;
            end
            @(negedge clk);
            check_writeback();
            hold = 1'b0;
            if (issue_valid) begin
                if (issue_ready) begin
                    record_accepted();
                    issued++;
                end else
                    hold = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;

        // Remaining loads and bus accesses drain
        drain = 0;
        while ((exp_q.size() != 0 || bus_q.size() != 0) && drain < 100) begin
            @(negedge clk);
            check_writeback();
            drain++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d issued loads never wrote back", exp_q.size());
        end
        assert (bus_q.size() == 0) else begin
            bus_errors++;
            $display("%0d issued bus accesses never reached the bus", bus_q.size());
        end
        // Quiet tail where any writeback is extra
        repeat (4) begin
            @(negedge clk);
            check_writeback();
        end

        $display("Closing: %0d writeback errors, %0d bus errors, %0d loads checked",
                 errors, bus_errors, loads_done);
        if (errors + bus_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
source/lsu_pkg.sv
source/lsu_fifo.sv
source/scratch_mem.sv
source/bus_master.sv
source/load_store_unit.sv
source/lsu_top.sv
bench/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module lsu_tb -f tb.f

out=$(./obj_dir/Vlsu_tb)
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -q "ALL TESTS PASSED"
